/* common/lsu_pkg.sv */
// shared load, store and size codes and widths for the memory stage, its memory and testbench
`default_nettype none

package lsu_pkg;

	// data and address width
	localparam int XLEN = 32;

	// field widths
	localparam int LOAD_W = 3;
	localparam int STORE_W = 2;
	localparam int SIZE_W = 3;
	localparam int REG_W = 5;
	// one strobe bit per byte lane
	localparam int STRB_W = XLEN / 8;

	// load type codes, any non-zero code is a load
	localparam logic [LOAD_W-1:0] LOAD_NONE = 3'd0;
	localparam logic [LOAD_W-1:0] LOAD_LB = 3'd1;
	localparam logic [LOAD_W-1:0] LOAD_LH = 3'd2;
	localparam logic [LOAD_W-1:0] LOAD_LW = 3'd3;
	localparam logic [LOAD_W-1:0] LOAD_LBU = 3'd4;
	localparam logic [LOAD_W-1:0] LOAD_LHU = 3'd5;

	// store type codes, any non-zero code is a store
	localparam logic [STORE_W-1:0] STORE_NONE = 2'd0;
	localparam logic [STORE_W-1:0] STORE_SB = 2'd1;
	localparam logic [STORE_W-1:0] STORE_SH = 2'd2;
	localparam logic [STORE_W-1:0] STORE_SW = 2'd3;

	// access size on the request bus, log2 of the byte count
	localparam logic [SIZE_W-1:0] SIZE_1 = 3'd0;
	localparam logic [SIZE_W-1:0] SIZE_2 = 3'd1;
	localparam logic [SIZE_W-1:0] SIZE_4 = 3'd2;

	// data memory depth in words, upper address bits alias
	localparam int RAM_WORD_BITS = 8;

	// largest number of extra wait cycles before pvalid
	localparam int MAX_WAIT = 3;
	// counter width able to hold MAX_WAIT
	localparam int WAIT_W = $clog2(MAX_WAIT + 1);

	// start value of the wait-picking lfsr, must not be zero
	localparam logic [15:0] LFSR_SEED = 16'hace1;

endpackage

`default_nettype wire

/* lsu/lsu_store_fmt.sv */
// store formatter for the memory stage, places store data on byte lanes and builds strobes
`timescale 1ns/1ns
`default_nettype none

module lsu_store_fmt import lsu_pkg::*; (
	input  logic [STORE_W-1:0] store_type_i,
	input  logic [1:0]         addr_lo_i,
	input  logic [XLEN-1:0]    wdata_i,
	output logic [XLEN-1:0]    pwdata_o,
	output logic [STRB_W-1:0]  pwstrb_o
);

	always_comb begin
		case (store_type_i)
			STORE_SB: begin
				// same byte on every lane, strobe picks the addressed one
				pwdata_o = {4{wdata_i[7:0]}};
				pwstrb_o = 4'b0001 << addr_lo_i;
			end
			STORE_SH: begin
				// halves are even-addressed so only bit 1 selects the lane pair
				pwdata_o = {2{wdata_i[15:0]}};
				pwstrb_o = 4'b0011 << {addr_lo_i[1], 1'b0};
			end
			STORE_SW: begin
				pwdata_o = wdata_i;
				pwstrb_o = 4'b1111;
			end
			default: begin
				// not a store, nothing gets written
				pwdata_o = wdata_i;
				pwstrb_o = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* lsu/lsu_load_align.sv */
// load aligner for the memory stage, shifts the read word to bit 0 and extends it per load type
`timescale 1ns/1ns
`default_nettype none

module lsu_load_align import lsu_pkg::*; (
	input  logic [LOAD_W-1:0] load_type_i,
	input  logic [1:0]        addr_lo_i,
	input  logic [XLEN-1:0]   rdata_i,
	output logic [XLEN-1:0]   ldata_o
);

	// addressed byte lands on bits 7:0
	logic [XLEN-1:0] shifted;

	// shift by eight bits per byte of offset
	assign shifted = rdata_i >> {addr_lo_i, 3'b000};

	always_comb begin
		case (load_type_i)
			// signed byte
			LOAD_LB: begin
				ldata_o = {{24{shifted[7]}}, shifted[7:0]};
			end
			// signed half
			LOAD_LH: begin
				ldata_o = {{16{shifted[15]}}, shifted[15:0]};
			end
			LOAD_LBU: begin
				ldata_o = {24'b0, shifted[7:0]};
			end
			LOAD_LHU: begin
				ldata_o = {16'b0, shifted[15:0]};
			end
			default: begin
				// word loads are aligned so offset is zero here
				ldata_o = shifted;
			end
		endcase
	end

endmodule

`default_nettype wire

/* lsu/lsu_stage.sv */
// memory-access pipeline stage, holds one instruction and drives the request bus to data memory
`timescale 1ns/1ns
`default_nettype none

module lsu_stage import lsu_pkg::*; (
	input  logic               clock,
	input  logic               rstn,
	// from execute
	input  logic               ex_valid_i,
	output logic               lsu_allowin_o,
	input  logic [XLEN-1:0]    alu_result_i,
	input  logic [XLEN-1:0]    mem_wdata_i,
	input  logic [LOAD_W-1:0]  load_type_i,
	input  logic [STORE_W-1:0] store_type_i,
	input  logic               wd_i,
	input  logic [REG_W-1:0]   wreg_i,
	// to writeback
	output logic               lsu_to_wbu_valid_o,
	input  logic               wbu_allowin_i,
	output logic               wb_wen_o,
	output logic [REG_W-1:0]   wb_reg_o,
	output logic [XLEN-1:0]    wb_data_o,
	// forward view for decode
	output logic               fwd_valid_o,
	output logic               fwd_stall_o,
	output logic [REG_W-1:0]   fwd_reg_o,
	output logic [XLEN-1:0]    fwd_data_o,
	// request bus
	output logic               psel_o,
	output logic               pwrite_o,
	output logic [XLEN-1:0]    paddr_o,
	output logic [SIZE_W-1:0]  psize_o,
	output logic [XLEN-1:0]    pwdata_o,
	output logic [STRB_W-1:0]  pwstrb_o,
	input  logic [XLEN-1:0]    prdata_i,
	input  logic               pvalid_i
);

	// control state
	logic               valid_r;
	logic               done_r;
	// held instruction
	logic [XLEN-1:0]    alu_r;
	logic [XLEN-1:0]    wdata_r;
	logic [LOAD_W-1:0]  load_r;
	logic [STORE_W-1:0] store_r;
	logic               wd_r;
	logic [REG_W-1:0]   wreg_r;
	// captured read word
	logic [XLEN-1:0]    rdata_r;

	logic               is_load;
	logic               is_store;
	logic               ready;
	logic               accept;
	logic [XLEN-1:0]    ldata;
	logic [XLEN-1:0]    result;

	assign is_load = |load_r;
	assign is_store = |store_r;
	// memory ops wait for the captured response, the rest are ready at once
	assign ready = ~(is_load | is_store) | done_r;

	assign lsu_allowin_o = ~valid_r | (ready & wbu_allowin_i);
	assign lsu_to_wbu_valid_o = valid_r & ready;
	assign accept = ex_valid_i & lsu_allowin_o;

	always_ff @(posedge clock) begin
		if (!rstn) begin
			valid_r <= 1'b0;
		end else if (lsu_allowin_o) begin
			valid_r <= ex_valid_i;
		end
	end

	// done clears whenever the slot turns over
	// and sets on the pvalid edge of the current request
	always_ff @(posedge clock) begin
		if (!rstn) begin
			done_r <= 1'b0;
		end else if (lsu_allowin_o) begin
			done_r <= 1'b0;
		end else if (psel_o && pvalid_i) begin
			done_r <= 1'b1;
		end
	end

	// payload only moves on acceptance
	always_ff @(posedge clock) begin
		if (accept) begin
			alu_r <= alu_result_i;
			wdata_r <= mem_wdata_i;
			load_r <= load_type_i;
			store_r <= store_type_i;
			wd_r <= wd_i;
			wreg_r <= wreg_i;
		end
	end

	// response held so writeback stalls after pvalid lose nothing
	always_ff @(posedge clock) begin
		if (psel_o && pvalid_i) begin
			rdata_r <= prdata_i;
		end
	end

	// request stays up until the response is captured
	assign psel_o = valid_r & (is_load | is_store) & ~done_r;
	assign pwrite_o = is_store;
	assign paddr_o = alu_r;

	always_comb begin
		if (is_load) begin
			case (load_r)
				LOAD_LB, LOAD_LBU: psize_o = SIZE_1;
				LOAD_LH, LOAD_LHU: psize_o = SIZE_2;
				default:           psize_o = SIZE_4;
			endcase
		end else begin
			case (store_r)
				STORE_SB: psize_o = SIZE_1;
				STORE_SH: psize_o = SIZE_2;
				default:  psize_o = SIZE_4;
			endcase
		end
	end

	lsu_store_fmt lsu_store_fmt_inst (
		.store_type_i (store_r),
		.addr_lo_i    (alu_r[1:0]),
		.wdata_i      (wdata_r),
		.pwdata_o     (pwdata_o),
		.pwstrb_o     (pwstrb_o)
	);

	lsu_load_align lsu_load_align_inst (
		.load_type_i (load_r),
		.addr_lo_i   (alu_r[1:0]),
		.rdata_i     (rdata_r),
		.ldata_o     (ldata)
	);

	// loads write back memory data, everything else the alu value
	assign result = is_load ? ldata : alu_r;

	assign wb_wen_o = wd_r;
	assign wb_reg_o = wreg_r;
	assign wb_data_o = result;

	// x0 is never forwarded
	assign fwd_valid_o = valid_r & wd_r & (wreg_r != '0);
	// decode must wait while the load value is still out on the bus
	assign fwd_stall_o = fwd_valid_o & is_load & ~done_r;
	assign fwd_reg_o = wreg_r;
	assign fwd_data_o = result;

endmodule

`default_nettype wire

/* hw/data_ram.sv */
// data memory behind the request bus, answers each request with pvalid after a random wait
`timescale 1ns/1ns
`default_nettype none

module data_ram import lsu_pkg::*; (
	input  logic              clock,
	input  logic              rstn,
	input  logic              psel_i,
	input  logic              pwrite_i,
	input  logic [XLEN-1:0]   paddr_i,
	input  logic [XLEN-1:0]   pwdata_i,
	input  logic [STRB_W-1:0] pwstrb_i,
	output logic [XLEN-1:0]   prdata_o,
	output logic              pvalid_o
);

	logic [XLEN-1:0]          mem [0:(1 << RAM_WORD_BITS)-1];

	logic [15:0]              lfsr;
	logic                     lfsr_fb;
	logic [WAIT_W-1:0]        pick_raw;
	logic [WAIT_W-1:0]        pick;
	logic                     busy;
	logic [WAIT_W-1:0]        cnt;
	logic                     fire;
	logic [RAM_WORD_BITS-1:0] widx;

	// memory starts cleared
	initial begin
		for (int i = 0; i < (1 << RAM_WORD_BITS); i++) begin
			mem[i] = '0;
		end
	end

	// taps 16 14 13 11, free running
	assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
	assign pick_raw = lfsr[WAIT_W-1:0];
	// clamp in case MAX_WAIT is not all ones
	assign pick = (pick_raw > WAIT_W'(MAX_WAIT)) ? WAIT_W'(MAX_WAIT) : pick_raw;

	// word index, byte offset and upper bits ignored
	assign widx = paddr_i[RAM_WORD_BITS+1:2];

	// answer now if idle with a zero pick, or once the countdown is spent
	// a request still up during its own pvalid cycle is not restarted
	assign fire = psel_i & ~pvalid_o & (busy ? (cnt == '0) : (pick == '0));

	always_ff @(posedge clock) begin
		if (!rstn) begin
			lfsr <= LFSR_SEED;
			busy <= 1'b0;
			cnt <= '0;
			pvalid_o <= 1'b0;
		end else begin
			lfsr <= {lfsr[14:0], lfsr_fb};
			pvalid_o <= fire;
			if (fire) begin
				busy <= 1'b0;
			end else if (psel_i && !pvalid_o) begin
				if (!busy) begin
					// first cycle of a slow request
					busy <= 1'b1;
					cnt <= pick - 1'b1;
				end else begin
					cnt <= cnt - 1'b1;
				end
			end
		end
	end

	// write lands on the same edge that raises pvalid
	always_ff @(posedge clock) begin
		if (fire && pwrite_i) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (pwstrb_i[b]) begin
					mem[widx][8*b +: 8] <= pwdata_i[8*b +: 8];
				end
			end
		end
	end

	// read word presented together with pvalid
	always_ff @(posedge clock) begin
		if (fire) begin
			prdata_o <= mem[widx];
		end
	end

endmodule

`default_nettype wire

/* hw/lsu_mem_top.sv */
// top level joining the memory stage to its data memory over the request bus
`timescale 1ns/1ns
`default_nettype none

module lsu_mem_top import lsu_pkg::*; (
	input  logic               clock,
	input  logic               rstn,
	// execute side
	input  logic               ex_valid_i,
	output logic               lsu_allowin_o,
	input  logic [XLEN-1:0]    alu_result_i,
	input  logic [XLEN-1:0]    mem_wdata_i,
	input  logic [LOAD_W-1:0]  load_type_i,
	input  logic [STORE_W-1:0] store_type_i,
	input  logic               wd_i,
	input  logic [REG_W-1:0]   wreg_i,
	// writeback side
	output logic               lsu_to_wbu_valid_o,
	input  logic               wbu_allowin_i,
	output logic               wb_wen_o,
	output logic [REG_W-1:0]   wb_reg_o,
	output logic [XLEN-1:0]    wb_data_o,
	// forward view
	output logic               fwd_valid_o,
	output logic               fwd_stall_o,
	output logic [REG_W-1:0]   fwd_reg_o,
	output logic [XLEN-1:0]    fwd_data_o
);

	// request bus between stage and memory
	logic              psel;
	logic              pwrite;
	logic [XLEN-1:0]   paddr;
	logic [XLEN-1:0]   pwdata;
	logic [STRB_W-1:0] pwstrb;
	logic [XLEN-1:0]   prdata;
	logic              pvalid;

	// memory takes no size, the strobes already say which bytes move
	lsu_stage lsu_stage_inst (
		.clock              (clock),
		.rstn               (rstn),
		.ex_valid_i         (ex_valid_i),
		.lsu_allowin_o      (lsu_allowin_o),
		.alu_result_i       (alu_result_i),
		.mem_wdata_i        (mem_wdata_i),
		.load_type_i        (load_type_i),
		.store_type_i       (store_type_i),
		.wd_i               (wd_i),
		.wreg_i             (wreg_i),
		.lsu_to_wbu_valid_o (lsu_to_wbu_valid_o),
		.wbu_allowin_i      (wbu_allowin_i),
		.wb_wen_o           (wb_wen_o),
		.wb_reg_o           (wb_reg_o),
		.wb_data_o          (wb_data_o),
		.fwd_valid_o        (fwd_valid_o),
		.fwd_stall_o        (fwd_stall_o),
		.fwd_reg_o          (fwd_reg_o),
		.fwd_data_o         (fwd_data_o),
		.psel_o             (psel),
		.pwrite_o           (pwrite),
		.paddr_o            (paddr),
		.psize_o            (),
		.pwdata_o           (pwdata),
		.pwstrb_o           (pwstrb),
		.prdata_i           (prdata),
		.pvalid_i           (pvalid)
	);

	data_ram data_ram_inst (
		.clock    (clock),
		.rstn     (rstn),
		.psel_i   (psel),
		.pwrite_i (pwrite),
		.paddr_i  (paddr),
		.pwdata_i (pwdata),
		.pwstrb_i (pwstrb),
		.prdata_o (prdata),
		.pvalid_o (pvalid)
	);

endmodule

`default_nettype wire

/* testbench/lsu_mem_chk.sv */
// request bus assertions, bound into every memory stage by the bind at the bottom
`timescale 1ns/1ns
`default_nettype none

module lsu_mem_chk import lsu_pkg::*; (
	input logic              clock,
	input logic              rstn,
	input logic              psel_o,
	input logic              pwrite_o,
	input logic [XLEN-1:0]   paddr_o,
	input logic [SIZE_W-1:0] psize_o,
	input logic [XLEN-1:0]   pwdata_o,
	input logic [STRB_W-1:0] pwstrb_o,
	input logic              pvalid_i
);

	// failure count, read by the testbench at the end of the run
	int unsigned fails = 0;

	// request held with every field frozen until the memory answers
	a_hold: assert property (@(posedge clock) disable iff (!rstn)
		psel_o && !pvalid_i |=> psel_o && $stable(pwrite_o) && $stable(paddr_o)
			&& $stable(psize_o) && $stable(pwdata_o) && $stable(pwstrb_o))
		else begin
			fails++;
			$error("request changed or dropped before pvalid");
		end

	// a response only ever answers an open request
	a_resp: assert property (@(posedge clock) disable iff (!rstn) pvalid_i |-> psel_o)
		else begin
			fails++;
			$error("pvalid without psel");
		end

	// byte count of the strobes follows the size code
	a_strb: assert property (@(posedge clock) disable iff (!rstn)
		psel_o && pwrite_o |->
			(psize_o == SIZE_1 && $countones(pwstrb_o) == 1)
			|| (psize_o == SIZE_2 && (pwstrb_o == 4'b0011 || pwstrb_o == 4'b1100))
			|| (psize_o == SIZE_4 && pwstrb_o == 4'b1111))
		else begin
			fails++;
			$error("pwstrb does not fit psize");
		end

endmodule

bind lsu_stage lsu_mem_chk lsu_mem_chk_inst (
	.clock    (clock),
	.rstn     (rstn),
	.psel_o   (psel_o),
	.pwrite_o (pwrite_o),
	.paddr_o  (paddr_o),
	.psize_o  (psize_o),
	.pwdata_o (pwdata_o),
	.pwstrb_o (pwstrb_o),
	.pvalid_i (pvalid_i)
);

`default_nettype wire

/* testbench/lsu_mem_tb.sv */
// self-checking testbench for the memory stage and its data memory, random traffic against a model
`timescale 1ns/1ns
`default_nettype none

module lsu_mem_tb import lsu_pkg::*; ();

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 8;
	localparam int N_INSTR = 400;
	// worst case per instruction is about 2+MAX_WAIT cycles, tripled for random stalls
	localparam int WATCHDOG_NS = (RESET_CYCLES + N_INSTR * (2 + MAX_WAIT) * 3 + 100) * CLK_PERIOD;

	// what writeback should see for one accepted instruction
	typedef struct packed {
		logic             wen;
		logic [REG_W-1:0] rd;
		logic [XLEN-1:0]  data;
		logic             is_load;
		logic             is_mem;
	} exp_t;

	logic               clock;
	logic               rstn;
	logic               ex_valid_i;
	logic               lsu_allowin_o;
	logic [XLEN-1:0]    alu_result_i;
	logic [XLEN-1:0]    mem_wdata_i;
	logic [LOAD_W-1:0]  load_type_i;
	logic [STORE_W-1:0] store_type_i;
	logic               wd_i;
	logic [REG_W-1:0]   wreg_i;
	logic               lsu_to_wbu_valid_o;
	logic               wbu_allowin_i;
	logic               wb_wen_o;
	logic [REG_W-1:0]   wb_reg_o;
	logic [XLEN-1:0]    wb_data_o;
	logic               fwd_valid_o;
	logic               fwd_stall_o;
	logic [REG_W-1:0]   fwd_reg_o;
	logic [XLEN-1:0]    fwd_data_o;

	// byte image of the first 64 words, updated in instruction order
	logic [7:0]         model_mem [0:255];
	exp_t               exp_q [$];
	logic [31:0]        rng;
	int                 accepted;
	int                 retired;
	logic               took;
	// cycles the oldest instruction has spent in the stage
	int                 head_age;
	// writeback outputs seen under back-pressure, must hold next cycle
	logic               hold_chk;
	logic               held_wen;
	logic [REG_W-1:0]   held_reg;
	logic [XLEN-1:0]    held_data;

	lsu_mem_top lsu_mem_top_inst (.*);

	always #(CLK_PERIOD / 2) clock = ~clock;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// number of request bus assertion failures so far
	function automatic int unsigned bus_fail_count();
		return lsu_mem_top_inst.lsu_stage_inst.lsu_mem_chk_inst.fails;
	endfunction

	task automatic draw(output logic [31:0] r);
		rng = xorshift32(rng);
		r = rng;
	endtask

	task automatic stop_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped after the first error");
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_fwd(input string name, input logic [REG_W-1:0] exp_rd,
			input logic [XLEN-1:0] exp_data, input logic [REG_W-1:0] act_rd,
			input logic [XLEN-1:0] act_data);
		if (act_rd !== exp_rd || act_data !== exp_data) begin
			$display("[FAIL] %s: expected reg=%0d data=%h, actual reg=%0d data=%h",
				name, exp_rd, exp_data, act_rd, act_data);
			stop_run();
		end
	endtask

	task automatic check_wb(input string name, input logic exp_wen, input logic [REG_W-1:0] exp_rd,
			input logic [XLEN-1:0] exp_data, input logic act_wen,
			input logic [REG_W-1:0] act_rd, input logic [XLEN-1:0] act_data);
		if (act_wen !== exp_wen || act_rd !== exp_rd || act_data !== exp_data) begin
			$display("[FAIL] %s: expected wen=%b reg=%0d data=%h, actual wen=%b reg=%0d data=%h",
				name, exp_wen, exp_rd, exp_data, act_wen, act_rd, act_data);
			stop_run();
		end
	endtask

	// pick the next offer from execute, kinds 0-1 alu, 2-4 stores, 5-9 loads
	task automatic new_offer();
		logic [31:0] r;
		int          kind;
		logic [1:0]  off;
		draw(r);
		ex_valid_i = (r[1:0] != 2'b00) && (accepted < N_INSTR);
		draw(r);
		kind = int'(r % 32'd10);
		off = r[9:8];
		load_type_i = LOAD_NONE;
		store_type_i = STORE_NONE;
		case (kind)
			2: store_type_i = STORE_SB;
			3: store_type_i = STORE_SH;
			4: store_type_i = STORE_SW;
			5: load_type_i = LOAD_LB;
			6: load_type_i = LOAD_LH;
			7: load_type_i = LOAD_LW;
			8: load_type_i = LOAD_LBU;
			9: load_type_i = LOAD_LHU;
			default: begin
			end
		endcase
		// align the offset to the access size
		if (kind == 3 || kind == 6 || kind == 9) begin
			off[0] = 1'b0;
		end else if (kind == 4 || kind == 7) begin
			off = 2'b00;
		end
		wd_i = r[12:10] != 3'b000;
		wreg_i = r[17:13];
		draw(r);
		alu_result_i = (kind < 2) ? r : {24'b0, r[5:0], off};
		draw(r);
		mem_wdata_i = r;
	endtask

	// apply an accepted instruction to the model and queue its writeback
	task automatic model_accept();
		exp_t       e;
		logic [7:0] a;
		logic [7:0] b0, b1, b2, b3;
		int         i;
		a = alu_result_i[7:0];
		e.wen = wd_i;
		e.rd = wreg_i;
		e.data = alu_result_i;
		e.is_load = load_type_i != LOAD_NONE;
		e.is_mem = e.is_load || (store_type_i != STORE_NONE);
		case (store_type_i)
			STORE_SB: model_mem[a] = mem_wdata_i[7:0];
			STORE_SH: begin
				model_mem[a] = mem_wdata_i[7:0];
				model_mem[a + 8'd1] = mem_wdata_i[15:8];
			end
			STORE_SW: begin
				for (i = 0; i < 4; i++) begin
					model_mem[a + 8'(i)] = mem_wdata_i[8*i +: 8];
				end
			end
			default: begin
			end
		endcase
		b0 = model_mem[a];
		b1 = model_mem[a + 8'd1];
		b2 = model_mem[a + 8'd2];
		b3 = model_mem[a + 8'd3];
		case (load_type_i)
			LOAD_LB:  e.data = {{24{b0[7]}}, b0};
			LOAD_LH:  e.data = {{16{b1[7]}}, b1, b0};
			LOAD_LW:  e.data = {b3, b2, b1, b0};
			LOAD_LBU: e.data = {24'b0, b0};
			LOAD_LHU: e.data = {16'b0, b1, b0};
			default: begin
			end
		endcase
		exp_q.push_back(e);
	endtask

	// runs at the falling edge, where inputs and outputs are settled for the coming edge
	task automatic check_cycle();
		exp_t cur;
		logic fv;
		if (exp_q.size() == 0) begin
			check_flag("idle_wb_valid", 1'b0, lsu_to_wbu_valid_o);
			check_flag("idle_fwd_valid", 1'b0, fwd_valid_o);
			check_flag("idle_fwd_stall", 1'b0, fwd_stall_o);
			check_flag("idle_allowin", 1'b1, lsu_allowin_o);
		end else begin
			cur = exp_q[0];
			fv = cur.wen && (cur.rd != '0);
			check_flag("fwd_valid", fv, fwd_valid_o);
			// non-memory results are ready as soon as they sit in the stage
			if (!cur.is_mem) begin
				check_flag("alu_ready", 1'b1, lsu_to_wbu_valid_o);
			end
			// memory results are ready 2 to 2+MAX_WAIT cycles after entry
			if (cur.is_mem && head_age < 2) begin
				check_flag("mem_early", 1'b0, lsu_to_wbu_valid_o);
			end
			if (cur.is_mem && head_age >= 2 + MAX_WAIT) begin
				check_flag("mem_late", 1'b1, lsu_to_wbu_valid_o);
			end
			check_flag("fwd_stall", fv && cur.is_load && !lsu_to_wbu_valid_o, fwd_stall_o);
			if (fv && !fwd_stall_o) begin
				check_fwd("fwd_data", cur.rd, cur.data, fwd_reg_o, fwd_data_o);
			end
			check_flag("allowin", lsu_to_wbu_valid_o && wbu_allowin_i, lsu_allowin_o);
			head_age++;
		end
		if (hold_chk) begin
			check_flag("bp_valid", 1'b1, lsu_to_wbu_valid_o);
			check_wb("bp_hold", held_wen, held_reg, held_data, wb_wen_o, wb_reg_o, wb_data_o);
		end
		hold_chk = lsu_to_wbu_valid_o && !wbu_allowin_i;
		held_wen = wb_wen_o;
		held_reg = wb_reg_o;
		held_data = wb_data_o;
		if (lsu_to_wbu_valid_o && wbu_allowin_i) begin
			if (exp_q.size() == 0) begin
				$display("writeback handshake with no instruction in flight");
				stop_run();
			end
			cur = exp_q[0];
			check_wb("writeback", cur.wen, cur.rd, cur.data, wb_wen_o, wb_reg_o, wb_data_o);
			void'(exp_q.pop_front());
			retired++;
			head_age = 0;
		end
		took = ex_valid_i && lsu_allowin_o;
		if (took) begin
			model_accept();
			accepted++;
		end
	endtask

	initial begin
		logic [31:0] r;
		clock = 1'b0;
		rstn = 1'b0;
		ex_valid_i = 1'b0;
		alu_result_i = '0;
		mem_wdata_i = '0;
		load_type_i = LOAD_NONE;
		store_type_i = STORE_NONE;
		wd_i = 1'b0;
		wreg_i = '0;
		wbu_allowin_i = 1'b0;
		rng = 32'h9995d9c6;
		accepted = 0;
		retired = 0;
		took = 1'b0;
		head_age = 0;
		hold_chk = 1'b0;
		for (int i = 0; i < 256; i++) begin
			model_mem[i] = 8'h00;
		end
		repeat (RESET_CYCLES) @(posedge clock);
		#2;
		rstn = 1'b1;
		@(negedge clock);
		check_flag("reset_wb_valid", 1'b0, lsu_to_wbu_valid_o);
		check_flag("reset_fwd_valid", 1'b0, fwd_valid_o);
		check_flag("reset_fwd_stall", 1'b0, fwd_stall_o);
		check_flag("reset_allowin", 1'b1, lsu_allowin_o);
		while (retired < N_INSTR) begin
			@(posedge clock);
			#2;
			draw(r);
			wbu_allowin_i = r[1:0] != 2'b00;
			// an offer stays up until execute sees it taken
			if (!ex_valid_i || took) begin
				new_offer();
			end
			@(negedge clock);
			check_cycle();
			if (bus_fail_count() != 0) begin
				$display("request bus assertion failed, see the error above");
				stop_run();
			end
		end
		// let the bus checker see the last cycles
		repeat (4) @(posedge clock);
		if (bus_fail_count() == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("%0d bus assertion failures", bus_fail_count());
			stop_run();
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: writeback did not retire all %0d instructions", N_INSTR);
		stop_run();
	end

endmodule

`default_nettype wire

/* lsu_mem_top.f */
common/lsu_pkg.sv
lsu/lsu_store_fmt.sv
lsu/lsu_load_align.sv
lsu/lsu_stage.sv
hw/data_ram.sv
hw/lsu_mem_top.sv
testbench/lsu_mem_chk.sv
testbench/lsu_mem_tb.sv

/* Makefile */
VERILATOR := verilator
TOP       := lsu_mem_tb
FILELIST  := lsu_mem_top.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing --assert --top-module $(TOP) -Mdir $(OBJDIR)
LINTFLAGS := --lint-only --timing --assert --top-module $(TOP)
# keep running past assertion failures so the testbench can report them at the end
SIMARGS   := +verilator+error+limit+1000

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJDIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) $(SIMARGS)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
